/* include/rv64_core_params.svh */
// data width, register count and reset program counter macros
`ifndef RV64_CORE_PARAMS_SVH
`define RV64_CORE_PARAMS_SVH

// machine word width
`define XLEN 64

// architectural integer registers
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

/* hw/rv64_core_pkg.sv */
// enums and packed structs for decoded control and execute results
`include "rv64_core_params.svh"

package rv64_core_pkg;

  // ALU operation codes, encodings follow the decoder's ALUctr
  typedef enum logic [3:0] {
    alu_add           = 4'b0000,
    alu_copy_imm      = 4'b0011,
    alu_sub           = 4'b1000,
    alu_add_word_sext = 4'b1001,
    alu_ebreak        = 4'b1110,
    alu_invalid       = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_bne  = 3'b101
  } branch_e;

  // load/store width and signedness
  typedef enum logic [2:0] {
    mem_sbyte = 3'b000,
    mem_ubyte = 3'b001,
    mem_shalf = 3'b010,
    mem_uhalf = 3'b011,
    mem_sword = 3'b100,
    mem_uword = 3'b101,
    mem_dword = 3'b110,
    mem_none  = 3'b111
  } mem_op_e;

  typedef enum logic {
    a_reg = 1'b0,
    a_pc  = 1'b1
  } a_src_e;

  typedef enum logic [1:0] {
    b_reg  = 2'b00,
    b_imm  = 2'b01,
    b_four = 2'b10
  } b_src_e;

  typedef struct packed {
    logic    reg_wr;
    a_src_e  a_src;
    b_src_e  b_src;
    alu_op_e alu_op;
    branch_e branch;
    logic    mem_to_reg;
    logic    mem_wr;
    mem_op_e mem_op;
  } ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0] alu_out;
    logic             branch_taken;
    logic             halt_req;
  } exe_res_t;

endpackage

/* hw/rv64_idu.sv */
// instruction decoder: register indices, immediate and control struct
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_idu (
  input  logic [31:0]           i_inst,
  output logic [4:0]            o_rs1,
  output logic [4:0]            o_rs2,
  output logic [4:0]            o_rd,
  output logic [`XLEN-1:0]      o_imm,
  output rv64_core_pkg::ctrl_t  o_ctrl
);

  import rv64_core_pkg::*;

  typedef enum logic [2:0] {
    fmt_r, fmt_i, fmt_u, fmt_s, fmt_b, fmt_j, fmt_none
  } fmt_e;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  fmt_e       fmt;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // supported instructions
  logic inst_lui, inst_auipc, inst_jal, inst_jalr, inst_bne, inst_lw;
  logic inst_sw, inst_sd, inst_addi, inst_addiw, inst_addw, inst_ebreak;

  assign inst_lui    = (opcode == 7'b0110111);
  assign inst_auipc  = (opcode == 7'b0010111);
  assign inst_jal    = (opcode == 7'b1101111);
  assign inst_jalr   = (opcode == 7'b1100111) && (funct3 == 3'b000);
  assign inst_bne    = (opcode == 7'b1100011) && (funct3 == 3'b001);
  assign inst_lw     = (opcode == 7'b0000011) && (funct3 == 3'b010);
  assign inst_sw     = (opcode == 7'b0100011) && (funct3 == 3'b010);
  assign inst_sd     = (opcode == 7'b0100011) && (funct3 == 3'b011);
  assign inst_addi   = (opcode == 7'b0010011) && (funct3 == 3'b000);
  assign inst_addiw  = (opcode == 7'b0011011) && (funct3 == 3'b000);
  assign inst_addw   = (opcode == 7'b0111011) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign inst_ebreak = (opcode == 7'b1110011) && (funct3 == 3'b000);

  always_comb begin
    if (inst_addw)
      fmt = fmt_r;
    else if (inst_lw || inst_addi || inst_addiw || inst_ebreak || inst_jalr)
      fmt = fmt_i;
    else if (inst_lui || inst_auipc)
      fmt = fmt_u;
    else if (inst_sw || inst_sd)
      fmt = fmt_s;
    else if (inst_bne)
      fmt = fmt_b;
    else if (inst_jal)
      fmt = fmt_j;
    else
      fmt = fmt_none;
  end

  // immediate of the selected format, sign extended to XLEN
  always_comb begin
    case (fmt)
      fmt_i:   o_imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
      fmt_u:   o_imm = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      fmt_s:   o_imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      fmt_b:   o_imm = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                        i_inst[30:25], i_inst[11:8], 1'b0};
      fmt_j:   o_imm = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                        i_inst[20], i_inst[30:21], 1'b0};
      default: o_imm = '0;
    endcase
  end

  always_comb begin
    o_ctrl.reg_wr     = (fmt == fmt_r) || (fmt == fmt_i) || (fmt == fmt_u) || (fmt == fmt_j);
    o_ctrl.a_src      = (inst_jal || inst_auipc || inst_jalr) ? a_pc : a_reg;
    o_ctrl.mem_to_reg = inst_lw;
    o_ctrl.mem_wr     = (fmt == fmt_s);

    // jumps add 4 to the pc for the link value, bne compares two registers
    case (fmt)
      fmt_i, fmt_u, fmt_s: o_ctrl.b_src = inst_jalr ? b_four : b_imm;
      fmt_j:               o_ctrl.b_src = b_four;
      default:             o_ctrl.b_src = b_reg;
    endcase

    if (inst_lw || inst_sw)
      o_ctrl.mem_op = mem_sword;
    else if (inst_sd)
      o_ctrl.mem_op = mem_dword;
    else
      o_ctrl.mem_op = mem_none;

    if (inst_lui)
      o_ctrl.alu_op = alu_copy_imm;
    else if (inst_auipc || inst_jal || inst_jalr || inst_lw || inst_sw || inst_addi || inst_sd)
      o_ctrl.alu_op = alu_add;
    else if (inst_addiw || inst_addw)
      o_ctrl.alu_op = alu_add_word_sext;
    else if (inst_bne)
      o_ctrl.alu_op = alu_sub;
    else if (inst_ebreak)
      o_ctrl.alu_op = alu_ebreak;
    else
      o_ctrl.alu_op = alu_invalid;

    if (inst_jal)
      o_ctrl.branch = br_jal;
    else if (inst_jalr)
      o_ctrl.branch = br_jalr;
    else if (inst_bne)
      o_ctrl.branch = br_bne;
    else
      o_ctrl.branch = br_none;
  end

endmodule

/* hw/rv64_regfile.sv */
// integer register file, two read ports and one write port, x0 reads zero
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_regfile (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic [$clog2(`REG_COUNT)-1:0] i_rs1,
  input  logic [$clog2(`REG_COUNT)-1:0] i_rs2,
  input  logic                          i_wr_en,
  input  logic [$clog2(`REG_COUNT)-1:0] i_rd,
  input  logic [`XLEN-1:0]              i_wr_data,
  output logic [`XLEN-1:0]              o_rs1_data,
  output logic [`XLEN-1:0]              o_rs2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end else if (i_wr_en && (i_rd != '0)) begin
      regs[i_rd] <= i_wr_data;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* hw/rv64_exu.sv */
// ALU with operand selection, word sign extension and branch judgement
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_exu (
  input  logic [`XLEN-1:0]         i_pc,
  input  logic [`XLEN-1:0]         i_rs1_data,
  input  logic [`XLEN-1:0]         i_rs2_data,
  input  logic [`XLEN-1:0]         i_imm,
  input  rv64_core_pkg::ctrl_t     i_ctrl,
  output rv64_core_pkg::exe_res_t  o_res
);

  import rv64_core_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] diff;

  assign op_a = (i_ctrl.a_src == a_pc) ? i_pc : i_rs1_data;

  always_comb begin
    case (i_ctrl.b_src)
      b_reg:   op_b = i_rs2_data;
      b_imm:   op_b = i_imm;
      b_four:  op_b = `XLEN'd4;
      default: op_b = '0;
    endcase
  end

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    case (i_ctrl.alu_op)
      alu_copy_imm:      o_res.alu_out = i_imm;
      alu_add:           o_res.alu_out = sum;
      // addw/addiw keep the low word and sign extend it
      alu_add_word_sext: o_res.alu_out = {{(`XLEN-32){sum[31]}}, sum[31:0]};
      alu_sub:           o_res.alu_out = diff;
      default:           o_res.alu_out = '0;
    endcase

    case (i_ctrl.branch)
      br_jal, br_jalr: o_res.branch_taken = 1'b1;
      br_bne:          o_res.branch_taken = |diff;
      default:         o_res.branch_taken = 1'b0;
    endcase

    o_res.halt_req = (i_ctrl.alu_op == alu_ebreak);
  end

endmodule

/* hw/rv64_wbu.sv */
// pc register, next-pc selection, write-back selection and halt latch
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_wbu (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  rv64_core_pkg::ctrl_t     i_ctrl,
  input  rv64_core_pkg::exe_res_t  i_res,
  input  logic [`XLEN-1:0]         i_rs1_data,
  input  logic [`XLEN-1:0]         i_imm,
  input  logic [`XLEN-1:0]         i_mem_rdata,
  output logic [`XLEN-1:0]         o_pc,
  output logic                     o_halt,
  output logic                     o_wr_en,
  output logic [`XLEN-1:0]         o_wr_data
);

  import rv64_core_pkg::*;

  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] load_data;
  logic             is_jump;

  assign pc_plus4 = o_pc + `XLEN'd4;
  assign is_jump  = (i_ctrl.branch == br_jal) || (i_ctrl.branch == br_jalr);

  always_comb begin
    case (i_ctrl.branch)
      br_jalr: target = (i_rs1_data + i_imm) & ~`XLEN'd1;
      default: target = o_pc + i_imm;
    endcase
  end

  assign next_pc = i_res.branch_taken ? target : pc_plus4;

  always_comb begin
    case (i_ctrl.mem_op)
      mem_sbyte: load_data = {{(`XLEN-8){i_mem_rdata[7]}}, i_mem_rdata[7:0]};
      mem_ubyte: load_data = {{(`XLEN-8){1'b0}}, i_mem_rdata[7:0]};
      mem_shalf: load_data = {{(`XLEN-16){i_mem_rdata[15]}}, i_mem_rdata[15:0]};
      mem_uhalf: load_data = {{(`XLEN-16){1'b0}}, i_mem_rdata[15:0]};
      mem_sword: load_data = {{(`XLEN-32){i_mem_rdata[31]}}, i_mem_rdata[31:0]};
      mem_uword: load_data = {{(`XLEN-32){1'b0}}, i_mem_rdata[31:0]};
      default:   load_data = i_mem_rdata;
    endcase
  end

  always_comb begin
    if (is_jump)
      o_wr_data = pc_plus4;
    else if (i_ctrl.mem_to_reg)
      o_wr_data = load_data;
    else
      o_wr_data = i_res.alu_out;
  end

  assign o_wr_en = i_ctrl.reg_wr & ~o_halt;

  // the pc stays on the ebreak once a halt is requested
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc   <= `RESET_PC;
      o_halt <= 1'b0;
    end else if (!o_halt) begin
      o_halt <= i_res.halt_req;
      if (!i_res.halt_req)
        o_pc <= next_pc;
    end
  end

endmodule

/* hw/rv64_core.sv */
// single-cycle RV64I core top level joining decode, registers, execute and write-back
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_core (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic [31:0]              i_inst,
  input  logic [`XLEN-1:0]         i_mem_rdata,
  output logic [`XLEN-1:0]         o_pc,
  output logic [`XLEN-1:0]         o_mem_addr,
  output logic [`XLEN-1:0]         o_mem_wdata,
  output rv64_core_pkg::mem_op_e   o_mem_op,
  output logic                     o_mem_wr,
  output logic                     o_halt
);

  import rv64_core_pkg::*;

  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [`XLEN-1:0] imm;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  exe_res_t         exe_res;
  logic             wr_en;
  logic [`XLEN-1:0] wr_data;

  rv64_idu u_idu (
    .i_inst (i_inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  rv64_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_wr_en    (wr_en),
    .i_rd       (rd),
    .i_wr_data  (wr_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv64_exu u_exu (
    .i_pc       (o_pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .i_ctrl     (ctrl),
    .o_res      (exe_res)
  );

  rv64_wbu u_wbu (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_ctrl      (ctrl),
    .i_res       (exe_res),
    .i_rs1_data  (rs1_data),
    .i_imm       (imm),
    .i_mem_rdata (i_mem_rdata),
    .o_pc        (o_pc),
    .o_halt      (o_halt),
    .o_wr_en     (wr_en),
    .o_wr_data   (wr_data)
  );

  // data memory port, address comes straight from the ALU
  assign o_mem_addr  = exe_res.alu_out;
  assign o_mem_wdata = rs2_data;
  assign o_mem_op    = ctrl.mem_op;
  assign o_mem_wr    = ctrl.mem_wr & ~o_halt & ~i_rst;

endmodule

/* verification/tb_clock.sv */
// clock generator for the testbench, 20 ns period
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk
);

  initial o_clk = 1'b0;

  // half period of 10 ns
  always #10 o_clk = ~o_clk;

endmodule

/* verification/rv64_core_assert.sv */
// concurrent assertions on reset, pc stepping and halt, bound into rv64_core
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_core_assert (
  input logic             i_clk,
  input logic             i_rst,
  input logic [`XLEN-1:0] i_pc,
  input logic             i_mem_wr,
  input logic             i_halt,
  input logic             i_taken,
  input logic             i_halt_req,
  input logic             i_wr_en
);

  // failed assertion attempts
  int fail_count = 0;

  // pc at the reset vector with halt and store strobe low, during reset and one cycle after
  reset_state: assert property (@(posedge i_clk)
    i_rst |=> (i_pc == `RESET_PC) && !i_halt && !i_mem_wr)
    else begin
      $error("pc not at reset vector, or halt or store strobe high after a reset cycle");
      fail_count++;
    end

  no_store_in_reset: assert property (@(posedge i_clk) i_rst |-> !i_mem_wr)
    else begin
      $error("memory write strobe high while reset is asserted");
      fail_count++;
    end

  // straight-line instructions move the pc by one word
  pc_step: assert property (@(posedge i_clk) disable iff (i_rst)
    (!i_rst && !i_halt && !i_taken && !i_halt_req) |=> (i_pc == $past(i_pc) + `XLEN'd4))
    else begin
      $error("pc did not advance by 4 after a sequential instruction");
      fail_count++;
    end

  halt_rise: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_halt_req && !i_halt) |=> i_halt)
    else begin
      $error("halt did not rise at the edge after ebreak");
      fail_count++;
    end

  halt_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_halt |=> i_halt && $stable(i_pc))
    else begin
      $error("halt dropped or pc moved while halted");
      fail_count++;
    end

  halt_quiet: assert property (@(posedge i_clk) i_halt |-> !i_mem_wr && !i_wr_en)
    else begin
      $error("memory or register write while halted");
      fail_count++;
    end

endmodule

bind rv64_core rv64_core_assert u_core_assert (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_pc       (o_pc),
  .i_mem_wr   (o_mem_wr),
  .i_halt     (o_halt),
  .i_taken    (exe_res.branch_taken),
  .i_halt_req (exe_res.halt_req),
  .i_wr_en    (wr_en)
);

/* verification/rv64_core_tb.sv */
// rv64_core testbench with memory models, test program, store checks and timeout
`timescale 1ns/1ps
`include "rv64_core_params.svh"

module rv64_core_tb;

  import rv64_core_pkg::*;

  localparam int reset_cycles = 8;
  localparam int prog_len     = 30;
  localparam int num_stores   = 9;
  // one cycle per instruction with slack for the jumps and the halt tail
  localparam int max_cycles   = reset_cycles + 6 * prog_len;

  // program at RESET_PC; the skipped slots and the tail hold sd x0,0(x5)
  localparam logic [31:0] program_words [32] = '{
    32'h000012B7, 32'h12300313, 32'h0062B023, 32'h800003B7,  // lui, addi, sd, lui
    32'h0072B423, 32'h00001417, 32'h0082B823, 32'h7FFFF4B7,  // sd, auipc, sd, lui
    32'h7FF4849B, 32'h0094853B, 32'h00A2BC23, 32'h0292B023,  // addiw, addw, sd, sd
    32'h0282A623, 32'h02C2A603, 32'h02C2B423, 32'h00031463,  // sw, lw, sd, bne taken
    32'h0002B023, 32'h00631463, 32'h00C006EF, 32'h0002B023,  // skip, bne, jal, skip
    32'h0002B023, 32'h02D2B823, 32'h00000717, 32'h010707E7,  // skip, sd, auipc, jalr
    32'h0002B023, 32'h0002B023, 32'h02F2BC23, 32'h00100073,  // skip, skip, sd, ebreak
    32'h0002B023, 32'h0002B023, 32'h0002B023, 32'h0002B023
  };

  // expected stores in program order
  // a word store compares only the low half of the data
  localparam logic [63:0] exp_addr [num_stores] = '{
    64'h1000, 64'h1008, 64'h1010, 64'h1018, 64'h1020,
    64'h102C, 64'h1028, 64'h1030, 64'h1038
  };
  localparam logic [63:0] exp_data [num_stores] = '{
    64'h0000_0000_0000_0123, 64'hFFFF_FFFF_8000_0000, 64'h0000_0000_8000_1014,
    64'hFFFF_FFFF_FFFF_EFFE, 64'h0000_0000_7FFF_F7FF, 64'h0000_0000_8000_1014,
    64'hFFFF_FFFF_8000_1014, 64'h0000_0000_8000_004C, 64'h0000_0000_8000_0060
  };
  localparam mem_op_e exp_op [num_stores] = '{
    mem_dword, mem_dword, mem_dword, mem_dword, mem_dword,
    mem_sword, mem_dword, mem_dword, mem_dword
  };

  logic             i_clk;
  logic             i_rst;
  logic [31:0]      i_inst;
  logic [`XLEN-1:0] i_mem_rdata;
  logic [`XLEN-1:0] o_pc;
  logic [`XLEN-1:0] o_mem_addr;
  logic [`XLEN-1:0] o_mem_wdata;
  mem_op_e          o_mem_op;
  logic             o_mem_wr;
  logic             o_halt;

  logic [63:0] dmem [128];
  logic [6:0]  dmem_idx;
  int          cycle_count;
  int          store_idx;
  int          check_errors;
  int          assert_errors;
  bit          timed_out;

  tb_clock u_clock (
    .o_clk (i_clk)
  );

  rv64_core i_rv64_core (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_inst      (i_inst),
    .i_mem_rdata (i_mem_rdata),
    .o_pc        (o_pc),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_mem_op    (o_mem_op),
    .o_mem_wr    (o_mem_wr),
    .o_halt      (o_halt)
  );

  // both memories answer in the same cycle
  assign i_inst      = program_words[o_pc[6:2]];
  assign dmem_idx    = o_mem_addr[9:3];
  assign i_mem_rdata = o_mem_addr[2] ? {32'b0, dmem[dmem_idx][63:32]} : dmem[dmem_idx];

  initial begin
    for (int i = 0; i < 128; i++)
      dmem[i] = i * 64'h0101_0101_0101_0101;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (o_mem_wr) begin
      if (o_mem_op == mem_dword)
        dmem[dmem_idx] <= o_mem_wdata;
      else if (o_mem_addr[2])
        dmem[dmem_idx][63:32] <= o_mem_wdata[31:0];
      else
        dmem[dmem_idx][31:0] <= o_mem_wdata[31:0];
    end
  end

  // compare each store against the table while the outputs are settled
  always @(negedge i_clk) begin
    if (!i_rst && o_mem_wr) begin
      if (store_idx >= num_stores) begin
        $display("unexpected extra store to address %h", o_mem_addr);
        check_errors = check_errors + 1;
      end else begin
        if (o_mem_addr !== exp_addr[store_idx]) begin
          $display("** Error at %0t: store %0d address %h, expected %h",
                   $time, store_idx, o_mem_addr, exp_addr[store_idx]);
          check_errors = check_errors + 1;
        end
        if (o_mem_op !== exp_op[store_idx]) begin
          $display("** Error at %0t: store %0d width code %0d, expected %0d",
                   $time, store_idx, o_mem_op, exp_op[store_idx]);
          check_errors = check_errors + 1;
        end
        if ((exp_op[store_idx] == mem_sword) ?
            (o_mem_wdata[31:0] !== exp_data[store_idx][31:0]) :
            (o_mem_wdata !== exp_data[store_idx])) begin
          $display("** Error at %0t: store %0d data %h, expected %h",
                   $time, store_idx, o_mem_wdata, exp_data[store_idx]);
          check_errors = check_errors + 1;
        end
      end
      store_idx = store_idx + 1;
    end
  end

  initial begin
    i_rst         = 1'b1;
    cycle_count   = 0;
    store_idx     = 0;
    check_errors  = 0;
    assert_errors = 0;
    timed_out     = 1'b0;
    repeat (reset_cycles) @(posedge i_clk);
    i_rst <= 1'b0;

    @(negedge i_clk);
    while (!o_halt && cycle_count < max_cycles)
      @(negedge i_clk);

    if (!o_halt) begin
      $display("timeout: core did not halt within %0d cycles", max_cycles);
      timed_out = 1'b1;
    end else begin
      // a few halted cycles so the halt assertions get exercised
      repeat (4) @(negedge i_clk);
      if (store_idx != num_stores) begin
        $display("saw %0d stores before halt, expected %0d", store_idx, num_stores);
        check_errors = check_errors + 1;
      end
    end

    assert_errors = i_rv64_core.u_core_assert.fail_count;
    $display("check errors: %0d, assertion errors: %0d", check_errors, assert_errors);
    if (check_errors == 0 && assert_errors == 0 && !timed_out)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* rv64_core.f */
+incdir+include
hw/rv64_core_pkg.sv
hw/rv64_idu.sv
hw/rv64_regfile.sv
hw/rv64_exu.sv
hw/rv64_wbu.sv
hw/rv64_core.sv
verification/tb_clock.sv
verification/rv64_core_assert.sv
verification/rv64_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f rv64_core.f --top-module rv64_core_tb -o rv64_core_sim \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/rv64_core_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
